//--- cpuController.f
+incdir+rtl
+incdir+test
rtl/cpuCtrlPkg.sv
rtl/instrDecoder.sv
rtl/ctrlSequencer.sv
rtl/ctrlOutputs.sv
rtl/cpuController.sv
test/cpuControllerTb.sv

//--- test/cpuControllerTests.svh
`ifndef CPU_CONTROLLER_TESTS_SVH
`define CPU_CONTROLLER_TESTS_SVH

// Field layout follows the instruction format
function automatic cpuCtrlPkg::opcodeT aTypeOp(input logic [2:0] s1, input logic [3:0] func,
                                             input logic [1:0] src2, input logic [2:0] dest);
    return {4'b0000, s1, func, src2, dest};
endfunction

function automatic cpuCtrlPkg::opcodeT iTypeOp(input logic [2:0] s1, input logic [2:0] dest);
    return {4'b0100, s1, 1'b0, dest, 5'd3}; // ADD with constant 3
endfunction

function automatic cpuCtrlPkg::opcodeT siTypeOp(input logic [2:0] s1, input logic [1:0] shift,
                                              input logic [2:0] dest);
    return {4'b0001, s1, shift, dest, 4'd0};
endfunction

function automatic cpuCtrlPkg::opcodeT fTypeOp(input logic val, input logic [1:0] sel);
    return {4'b0010, val, sel, 1'b0, 8'd0};
endfunction

function automatic cpuCtrlPkg::opcodeT stackOp(input logic [2:0] s1, input logic [1:0] kind);
    return {4'b0011, s1, kind, 7'd0}; // kind 00 push, 01 pop
endfunction

task automatic verify(input bit cond, input string msg);
    assert (cond) else begin
        $display("[ERROR] %0t: %s", $time, msg);
        errCount++;
    end
endtask

// Outputs are stable at the falling edge, where stimulus is also driven
task automatic stepExpect(input cpuCtrlPkg::ctrlState exp);
    @(negedge clk);
    verify(state == exp, $sformatf("state %s, expected %s", state.name(), exp.name()));
endtask

task automatic reportTest(input string name, input int errsBefore);
    testCount++;
    if (errCount == errsBefore) begin
        $display("Test %s passed", name);
    end else begin
        failedTests++;
        $display("Test %s FAILED with %0d errors", name, errCount - errsBefore);
    end
endtask

task automatic testReset();
    int errsBefore;
    cpuCtrlPkg::ctrlBus startCtrl;
    errsBefore = errCount;
    startCtrl = '0; // SP and FP initialisation only
    startCtrl.initSPFP = 1'b1;
    startCtrl.enSP = 1'b1;
    startCtrl.enFP = 1'b1;
    repeat (RESET_CYCLES) begin
        @(negedge clk);
        verify(state == cpuCtrlPkg::START, "state is not START during reset");
        verify(!ctrl.we && !ctrl.re && !ctrl.enPC && !ctrl.saveOpcode,
               "we, re, enPC or saveOpcode high during reset");
        verify(ctrl == startCtrl, "START drives more than initSPFP, enSP and enFP");
    end
    rst = 1'b0;
    stepExpect(cpuCtrlPkg::FETCH);
    verify(ctrl.re && ctrl.saveOpcode && ctrl.enPC, "fetch controls low in FETCH");
    reportTest("reset", errsBefore);
endtask

task automatic testAType();
    int errsBefore;
    logic [2:0] dest;
    cpuCtrlPkg::opcodeT op;
    errsBefore = errCount;
    dest = 3'($urandom_range(1, 3)); // Register A, B or C
    op = aTypeOp(3'($urandom_range(0, 3)), 4'($urandom), 2'($urandom), dest);
    opcode = op;
    stepExpect(cpuCtrlPkg::ATYPE);
    verify(ctrl.aluFunc == op[8:5], "ATYPE aluFunc differs from opcode bits 8:5");
    verify({ctrl.enA, ctrl.enB, ctrl.enC} == (3'b100 >> (dest - 3'd1)),
           "ATYPE register enables do not match the destination");
    stepExpect(cpuCtrlPkg::FETCH);
    reportTest("A-type register", errsBefore);
endtask

task automatic testReadWriteModes();
    int errsBefore;
    cpuCtrlPkg::ctrlState absSeq [6] = '{cpuCtrlPkg::RIMMED, cpuCtrlPkg::ITYPE,
        cpuCtrlPkg::WABS1, cpuCtrlPkg::WABS2, cpuCtrlPkg::WABS3, cpuCtrlPkg::FETCH};
    errsBefore = errCount;
    opcode = iTypeOp(`SRC_IMMED, `DEST_ABS);
    foreach (absSeq[i]) begin
        stepExpect(absSeq[i]);
        verify(ctrl.we == (absSeq[i] == cpuCtrlPkg::WABS3), "we wrong for this state");
    end
    opcode = siTypeOp(`SRC_STACK, 2'($urandom), 3'($urandom_range(1, 3)));
    stepExpect(cpuCtrlPkg::RSTACK1);
    stepExpect(cpuCtrlPkg::RSTACK2);
    stepExpect(cpuCtrlPkg::SITYPE);
    stepExpect(cpuCtrlPkg::FETCH);
    reportTest("read and write modes", errsBefore);
endtask

task automatic testBranches();
    int errsBefore;
    logic [1:0] sel;
    logic val;
    errsBefore = errCount;
    for (int i = 0; i < 6; i++) begin
        sel = 2'($urandom);
        flags = 4'($urandom);
        val = (i % 2 == 0) ? flags[sel] : !flags[sel]; // Alternate taken and untaken
        opcode = fTypeOp(val, sel);
        if (flags[sel] == val) begin
            stepExpect(cpuCtrlPkg::FTYPE); // Taken
            verify(ctrl.enPC, "enPC low in FTYPE");
        end
        stepExpect(cpuCtrlPkg::FETCH);
    end
    opcode = {1'b1, 15'($urandom)};
    stepExpect(cpuCtrlPkg::JTYPE);
    verify(ctrl.enPC, "enPC low in JTYPE");
    stepExpect(cpuCtrlPkg::FETCH);
    reportTest("branches", errsBefore);
endtask

task automatic testStack();
    int errsBefore;
    errsBefore = errCount;
    opcode = stackOp(3'($urandom_range(1, 3)), 2'b00);
    stepExpect(cpuCtrlPkg::PUSH1);
    verify(ctrl.we && ctrl.readStack, "we or readStack low in PUSH1");
    stepExpect(cpuCtrlPkg::PUSH2);
    verify(ctrl.enSP && ctrl.aluFunc == `ALU_SUB, "PUSH2 does not decrement SP");
    stepExpect(cpuCtrlPkg::FETCH);
    opcode = stackOp(3'($urandom_range(1, 3)), 2'b01);
    stepExpect(cpuCtrlPkg::POP1);
    verify(ctrl.re && ctrl.enSP, "re or enSP low in POP1");
    stepExpect(cpuCtrlPkg::POP2);
    stepExpect(cpuCtrlPkg::FETCH);
    reportTest("stack", errsBefore);
endtask

task automatic testStall();
    int errsBefore;
    cpuCtrlPkg::ctrlBus heldCtrl;
    errsBefore = errCount;
    opcode = aTypeOp(3'd1, 4'($urandom), 2'($urandom), `DEST_ABS);
    stepExpect(cpuCtrlPkg::ATYPE);
    stepExpect(cpuCtrlPkg::WABS1);
    heldCtrl = ctrl;
    stall = 1'b1; // Freeze in the middle of the write sequence
    repeat (STALL_CYCLES) begin
        @(negedge clk);
        verify(state == cpuCtrlPkg::WABS1 && ctrl == heldCtrl,
               "state or ctrl moved while stalled");
    end
    stall = 1'b0;
    stepExpect(cpuCtrlPkg::WABS2);
    stepExpect(cpuCtrlPkg::WABS3);
    stepExpect(cpuCtrlPkg::FETCH);
    reportTest("stall", errsBefore);
endtask

task automatic testInvalidOpcode();
    int errsBefore;
    errsBefore = errCount;
    opcode = {4'b0010, 3'd0, 1'b1, 8'd0}; // Former load/save encoding
    stepExpect(cpuCtrlPkg::HALT);
    repeat (4) stepExpect(cpuCtrlPkg::HALT);
    rst = 1'b1;
    stepExpect(cpuCtrlPkg::START);
    rst = 1'b0;
    stepExpect(cpuCtrlPkg::FETCH);
    reportTest("invalid opcode", errsBefore);
endtask

`endif

//--- test/cpuControllerTb.sv
`default_nettype none

`include "cpuCtrl_defines.svh"

module cpuControllerTb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int STALL_CYCLES = 5;
    // Reset, A-type, read/write modes, branches, stack, stall, halt
    localparam int TEST_CYCLES = 11 + 2 + 10 + 11 + 6 + 10 + 7;

    logic clk = 1'b0;
    logic rst;
    logic stall;
    cpuCtrlPkg::opcodeT opcode;
    cpuCtrlPkg::flagsT flags;
    cpuCtrlPkg::ctrlBus ctrl;
    cpuCtrlPkg::ctrlState state;

    int errCount = 0;
    int testCount = 0;
    int failedTests = 0;

    cpuController uut (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .opcode (opcode),
        .flags  (flags),
        .ctrl   (ctrl),
        .state  (state)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    `include "cpuControllerTests.svh"

    // Generous margin over the summed test lengths
    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish within %0d cycles",
                 TEST_CYCLES * 4);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(60));
        rst = 1'b1; // Held for RESET_CYCLES in testReset
        stall = 1'b0;
        opcode = '0;
        flags = '0;

        testReset();
        testAType();
        testReadWriteModes();
        testBranches();
        testStack();
        testStall();
        testInvalidOpcode();

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 testCount, failedTests, errCount);
        if (errCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/cpuController.sv
`default_nettype none

module cpuController (
    input wire clk,
    input wire rst,
    input wire stall, // Holds state and outputs
    input wire cpuCtrlPkg::opcodeT opcode,
    input wire cpuCtrlPkg::flagsT flags,
    output cpuCtrlPkg::ctrlBus ctrl,
    output cpuCtrlPkg::ctrlState state // Debug view
);

    wire cpuCtrlPkg::decodedInstr decoded;

    instrDecoder decoder (
        .opcode  (opcode),
        .flags   (flags),
        .decoded (decoded)
    );

    ctrlSequencer sequencer (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .decoded (decoded),
        .state   (state)
    );

    ctrlOutputs outputs (
        .state   (state),
        .opcode  (opcode),
        .decoded (decoded),
        .ctrl    (ctrl)
    );

endmodule

`default_nettype wire

//--- rtl/ctrlOutputs.sv
`default_nettype none

`include "cpuCtrl_defines.svh"

module ctrlOutputs (
    input wire cpuCtrlPkg::ctrlState state,
    input wire cpuCtrlPkg::opcodeT opcode,
    input wire cpuCtrlPkg::decodedInstr decoded,
    output cpuCtrlPkg::ctrlBus ctrl
);

    // Register operand or the word read from memory
    function automatic cpuCtrlPkg::srcSelT operandA(input cpuCtrlPkg::destT mode);
        return mode[2] ? `ALU1_FROM_MEM : {2'b00, mode[1:0]};
    endfunction

    function automatic cpuCtrlPkg::ctrlBus pcIncrement(input cpuCtrlPkg::ctrlBus c);
        c.aluFunc = `ALU_ADD;
        c.aluA = `ALU1_FROM_PC;
        c.aluB = `ALU2_FROM_1;
        c.enPC = 1'b1;
        return c;
    endfunction

    // Destination enables shared by the main states and POP2
    function automatic cpuCtrlPkg::ctrlBus writeBack(input cpuCtrlPkg::ctrlBus c,
                                                     input cpuCtrlPkg::destT dest);
        case (dest)
            `DEST_A: c.enA = 1'b1;
            `DEST_B: c.enB = 1'b1;
            `DEST_C: c.enC = 1'b1;
            `DEST_ADR: begin
                c.we = 1'b1;
                c.writeDataSource = `WRITE_FROM_ALU;
                c.memAddr = `READ_FROM_A;
            end
            `DEST_ABS, `DEST_STACK: c.saveResult = 1'b1; // Written by WABS or WSTACK
            default: c.saveResult = 1'b0;
        endcase
        return c;
    endfunction

    always_comb begin
        ctrl = '0;
        case (state)
            cpuCtrlPkg::START: begin
                ctrl.initSPFP = 1'b1;
                ctrl.enSP = 1'b1;
                ctrl.enFP = 1'b1;
            end
            cpuCtrlPkg::FETCH: begin
                ctrl.memAddr = `READ_FROM_PC;
                ctrl.re = 1'b1;
                ctrl.saveOpcode = 1'b1;
                ctrl = pcIncrement(ctrl);
            end
            cpuCtrlPkg::ATYPE: begin
                ctrl.aluA = operandA(decoded.srcMode);
                ctrl.aluB = {2'b00, opcode[`OP_A_SRC2]};
                ctrl.aluFunc = decoded.aluFunc;
                ctrl.enF = 1'b1;
                ctrl = writeBack(ctrl, decoded.dest);
            end
            cpuCtrlPkg::ITYPE, cpuCtrlPkg::SITYPE: begin
                ctrl.aluA = operandA(decoded.srcMode);
                if (state == cpuCtrlPkg::ITYPE && decoded.srcMode == 3'd0)
                    ctrl.aluA = `ALU1_FROM_SP; // Register 0 means SP here
                ctrl.aluB = `ALU2_FROM_OP; // Constant from opcode
                ctrl.aluFunc = decoded.aluFunc;
                ctrl.enF = 1'b1;
                if (state == cpuCtrlPkg::ITYPE && decoded.dest == `DEST_0)
                    ctrl.enSP = 1'b1;
                else
                    ctrl = writeBack(ctrl, decoded.dest);
            end
            cpuCtrlPkg::JTYPE, cpuCtrlPkg::FTYPE: begin
                ctrl.aluA = `ALU1_FROM_PC;
                ctrl.aluB = (state == cpuCtrlPkg::JTYPE) ? `ALU2_FROM_ADDR : `ALU2_FROM_OP;
                ctrl.aluFunc = `ALU_ADD;
                ctrl.enPC = 1'b1;
            end
            cpuCtrlPkg::PUSH1: begin
                ctrl.aluA = operandA(decoded.srcMode);
                ctrl.aluB = `ALU2_FROM_0;
                ctrl.aluFunc = `ALU_ADD;
                ctrl.we = 1'b1;
                ctrl.readStack = 1'b1;
                ctrl.writeDataSource = `WRITE_FROM_ALU;
                ctrl.memAddr = `READ_FROM_SP;
            end
            cpuCtrlPkg::PUSH2: begin
                ctrl.aluA = `ALU1_FROM_SP;
                ctrl.aluB = `ALU2_FROM_1;
                ctrl.aluFunc = `ALU_SUB; // SP down
                ctrl.enSP = 1'b1;
            end
            cpuCtrlPkg::POP1: begin
                ctrl.aluA = `ALU1_FROM_SP;
                ctrl.aluB = `ALU2_FROM_1;
                ctrl.aluFunc = `ALU_ADD; // SP up, read new top
                ctrl.enSP = 1'b1;
                ctrl.memAddr = `READ_FROM_ALU;
                ctrl.readStack = 1'b1;
                ctrl.saveMem1 = 1'b1;
                ctrl.re = 1'b1;
            end
            cpuCtrlPkg::POP2: begin
                ctrl.aluA = `ALU1_FROM_MEM;
                ctrl.aluB = `ALU2_FROM_0;
                ctrl.aluFunc = `ALU_ADD;
                if (decoded.dest == `DEST_0) begin
                    ctrl.enF = 1'b1; // Pop into flags
                    ctrl.sourceF = 1'b1;
                end else begin
                    ctrl = writeBack(ctrl, decoded.dest);
                end
            end
            cpuCtrlPkg::RIMMED, cpuCtrlPkg::RABS2, cpuCtrlPkg::RSTACK1,
            cpuCtrlPkg::WABS2, cpuCtrlPkg::WSTACK1: begin
                ctrl.memAddr = `READ_FROM_PC;
                ctrl.saveMem1 = 1'b1;
                ctrl.re = 1'b1;
                ctrl = pcIncrement(ctrl);
            end
            cpuCtrlPkg::RABS1, cpuCtrlPkg::WABS1: begin
                ctrl.memAddr = `READ_FROM_PC;
                ctrl.saveMem2 = 1'b1;
                ctrl.re = 1'b1;
                ctrl = pcIncrement(ctrl);
            end
            cpuCtrlPkg::RADDRESS: begin
                ctrl.memAddr = `READ_FROM_A;
                ctrl.saveMem1 = 1'b1;
                ctrl.re = 1'b1;
            end
            cpuCtrlPkg::RABS3, cpuCtrlPkg::WABS3: begin
                ctrl.memAddr = `READ_FROM_ALU; // Full address from both words
                ctrl.aluA = `ALU1_FROM_HIMEM;
                ctrl.aluB = `ALU2_FROM_0;
                ctrl.aluFunc = `ALU_ADD;
                ctrl.saveMem1 = (state == cpuCtrlPkg::RABS3);
                ctrl.re = (state == cpuCtrlPkg::RABS3);
                ctrl.we = (state == cpuCtrlPkg::WABS3);
                if (state == cpuCtrlPkg::WABS3)
                    ctrl.writeDataSource = `WRITE_FROM_RES;
            end
            cpuCtrlPkg::RSTACK2, cpuCtrlPkg::WSTACK2: begin
                ctrl.memAddr = `READ_FROM_ALU; // Offset plus FP
                ctrl.aluA = `ALU1_FROM_MEM;
                ctrl.aluB = `ALU2_FROM_FP;
                ctrl.aluFunc = `ALU_ADD;
                ctrl.readStack = 1'b1;
                ctrl.saveMem1 = (state == cpuCtrlPkg::RSTACK2);
                ctrl.re = (state == cpuCtrlPkg::RSTACK2);
                ctrl.we = (state == cpuCtrlPkg::WSTACK2);
                if (state == cpuCtrlPkg::WSTACK2)
                    ctrl.writeDataSource = `WRITE_FROM_RES;
            end
            default: ctrl = '0; // HALT drives nothing
        endcase
    end

    // Memory port is single sided over every state and destination
    always_comb begin
        weReExclusive: assert #0 (!(ctrl.we && ctrl.re))
            else $error("we and re high together in state %s", state.name());
    end

endmodule

`default_nettype wire

//--- rtl/ctrlSequencer.sv
`default_nettype none

`include "cpuCtrl_defines.svh"

module ctrlSequencer (
    input wire clk,
    input wire rst,
    input wire stall,
    input wire cpuCtrlPkg::decodedInstr decoded,
    output cpuCtrlPkg::ctrlState state
);

    cpuCtrlPkg::ctrlState nextState;
    cpuCtrlPkg::ctrlState readState; // First state after FETCH
    cpuCtrlPkg::ctrlState wbState; // State after the main state

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpuCtrlPkg::START;
        end else if (!stall) begin
            state <= nextState;
        end
    end

    // Operand read dispatch
    always_comb begin
        readState = decoded.mainState;
        if (decoded.needsRead) begin
            case (decoded.srcMode)
                `SRC_IMMED: readState = cpuCtrlPkg::RIMMED;
                `SRC_ABS:   readState = cpuCtrlPkg::RABS1;
                `SRC_ADDR:  readState = cpuCtrlPkg::RADDRESS;
                `SRC_STACK: readState = cpuCtrlPkg::RSTACK1;
                default:    readState = decoded.mainState;
            endcase
        end
    end

    // Write-back dispatch
    always_comb begin
        case (decoded.dest)
            `DEST_ABS:   wbState = cpuCtrlPkg::WABS1;
            `DEST_STACK: wbState = cpuCtrlPkg::WSTACK1;
            default:     wbState = cpuCtrlPkg::FETCH; // Register or memory at A
        endcase
    end

    always_comb begin
        nextState = cpuCtrlPkg::HALT;
        case (state)
            cpuCtrlPkg::START: nextState = cpuCtrlPkg::FETCH;
            cpuCtrlPkg::FETCH: nextState = readState;

            cpuCtrlPkg::RIMMED,
            cpuCtrlPkg::RADDRESS,
            cpuCtrlPkg::RABS3,
            cpuCtrlPkg::RSTACK2: nextState = decoded.mainState;

            cpuCtrlPkg::RABS1:   nextState = cpuCtrlPkg::RABS2;
            cpuCtrlPkg::RABS2:   nextState = cpuCtrlPkg::RABS3;
            cpuCtrlPkg::RSTACK1: nextState = cpuCtrlPkg::RSTACK2;

            cpuCtrlPkg::ATYPE,
            cpuCtrlPkg::ITYPE,
            cpuCtrlPkg::SITYPE,
            cpuCtrlPkg::POP2: nextState = wbState;

            cpuCtrlPkg::PUSH1: nextState = cpuCtrlPkg::PUSH2;
            cpuCtrlPkg::POP1:  nextState = cpuCtrlPkg::POP2;

            cpuCtrlPkg::WABS1:   nextState = cpuCtrlPkg::WABS2;
            cpuCtrlPkg::WABS2:   nextState = cpuCtrlPkg::WABS3;
            cpuCtrlPkg::WSTACK1: nextState = cpuCtrlPkg::WSTACK2;

            cpuCtrlPkg::JTYPE,
            cpuCtrlPkg::FTYPE,
            cpuCtrlPkg::PUSH2,
            cpuCtrlPkg::WABS3,
            cpuCtrlPkg::WSTACK2: nextState = cpuCtrlPkg::FETCH;

            cpuCtrlPkg::HALT: nextState = cpuCtrlPkg::HALT; // Only rst leaves
            default:          nextState = cpuCtrlPkg::HALT;
        endcase
    end

    haltIsSticky: assert property (
        @(posedge clk) (state == cpuCtrlPkg::HALT && !rst) |=> state == cpuCtrlPkg::HALT
    ) else $error("state left HALT without reset");

    stallHoldsState: assert property (
        @(posedge clk) (stall && !rst) |=> $stable(state)
    ) else $error("state moved while stalled");

endmodule

`default_nettype wire

//--- rtl/instrDecoder.sv
`default_nettype none

`include "cpuCtrl_defines.svh"

module instrDecoder (
    input wire cpuCtrlPkg::opcodeT opcode,
    input wire cpuCtrlPkg::flagsT flags,
    output cpuCtrlPkg::decodedInstr decoded
);

    logic [3:0] opClass;
    logic isAType;
    logic isIType;
    logic isJType;
    logic isSIType;
    logic isFType;
    logic isPush;
    logic isPop;
    logic condMet;

    assign opClass = opcode[`OP_CLASS];

    assign isAType = (opClass == 4'b0000);
    assign isIType = (opClass[3:2] == 2'b01);
    assign isJType = opClass[3];
    assign isSIType = (opClass == 4'b0001);
    assign isFType = (opClass == 4'b0010) && !opcode[8]; // Bit 8 set was load/save
    assign isPush = (opClass == 4'b0011) && (opcode[`OP_SP_KIND] == 2'b00);
    assign isPop = (opClass == 4'b0011) && (opcode[`OP_SP_KIND] == 2'b01);

    // Selected flag compared against the wanted value
    assign condMet = (flags[opcode[`OP_COND_FLAG]] == opcode[`OP_COND_VAL]);

    always_comb begin
        decoded = '0;
        decoded.mainState = cpuCtrlPkg::HALT; // Unknown or dropped class
        decoded.srcMode = opcode[`OP_S1];
        decoded.dest = `DEST_0;
        decoded.aluFunc = `ALU_ADD;

        if (isAType) begin
            decoded.mainState = cpuCtrlPkg::ATYPE;
            decoded.dest = opcode[`OP_A_DEST];
            decoded.aluFunc = opcode[`OP_A_FUNC]; // Function straight from opcode
        end else if (isIType) begin
            decoded.mainState = cpuCtrlPkg::ITYPE;
            decoded.dest = opcode[`OP_I_DEST];
            decoded.aluFunc = {opcode[8], opcode[8], opcode[13:12]};
        end else if (isJType) begin
            decoded.mainState = cpuCtrlPkg::JTYPE;
        end else if (isSIType) begin
            decoded.mainState = cpuCtrlPkg::SITYPE;
            decoded.dest = opcode[`OP_SI_DEST];
            decoded.aluFunc = {2'b10, opcode[`OP_SI_SHIFT]}; // Shift group
        end else if (isFType) begin
            // Untaken branch goes straight back to fetch
            decoded.mainState = condMet ? cpuCtrlPkg::FTYPE : cpuCtrlPkg::FETCH;
        end else if (isPush) begin
            decoded.mainState = cpuCtrlPkg::PUSH1;
        end else if (isPop) begin
            decoded.mainState = cpuCtrlPkg::POP1;
            decoded.dest = opcode[`OP_S1]; // Pop writes to s1
        end

        decoded.needsRead = opcode[`OP_S1] > 3'd3
            && (isAType || isIType || isSIType || isPush);
    end

endmodule

`default_nettype wire

//--- rtl/cpuCtrlPkg.sv
`default_nettype none

`include "cpuCtrl_defines.svh"

package cpuCtrlPkg;

    typedef logic [`OPCODE_W-1:0] opcodeT;
    typedef logic [`FLAGS_W-1:0] flagsT;
    typedef logic [3:0] aluFuncT;
    typedef logic [`SEL_W-1:0] srcSelT;
    typedef logic [`ADDRSEL_W-1:0] addrSelT;
    typedef logic [2:0] destT;

    typedef enum logic [5:0] {
        START    = 6'd0,
        FETCH    = 6'd1,
        ATYPE    = 6'd2,
        ITYPE    = 6'd3,
        JTYPE    = 6'd4,
        SITYPE   = 6'd5,
        FTYPE    = 6'd6,
        PUSH1    = 6'd8,
        PUSH2    = 6'd9,
        POP1     = 6'd10,
        POP2     = 6'd11,
        RIMMED   = 6'd20,
        RADDRESS = 6'd21,
        RABS1    = 6'd22, // Low address word
        RABS2    = 6'd23, // High address word
        RABS3    = 6'd24, // Operand read
        RSTACK1  = 6'd25,
        RSTACK2  = 6'd26,
        WABS1    = 6'd27,
        WABS2    = 6'd28,
        WABS3    = 6'd31, // Result write
        WSTACK1  = 6'd29,
        WSTACK2  = 6'd30,
        HALT     = 6'd63
    } ctrlState;

    typedef struct packed {
        ctrlState mainState; // Main state of the class
        destT srcMode; // s1 field
        destT dest;
        logic needsRead; // Operand comes from memory
        aluFuncT aluFunc;
    } decodedInstr;

    typedef struct packed {
        addrSelT memAddr;
        logic enPC;
        logic saveOpcode;
        logic saveMem1;
        logic saveMem2;
        logic enFP;
        aluFuncT aluFunc;
        srcSelT aluA;
        srcSelT aluB;
        logic enA;
        logic enB;
        logic enC;
        logic we;
        logic re;
        srcSelT writeDataSource;
        logic saveResult; // Latch ALU result for later write
        logic enF;
        logic sourceF; // Flags loaded from ALU output
        logic enSP;
        logic readStack;
        logic initSPFP;
    } ctrlBus;

endpackage

`default_nettype wire

//--- rtl/cpuCtrl_defines.svh
`ifndef CPUCTRL_DEFINES_SVH
`define CPUCTRL_DEFINES_SVH

// Widths
`define OPCODE_W 16
`define FLAGS_W 4
`define SEL_W 4
`define ADDRSEL_W 3

// Opcode field positions
`define OP_CLASS 15:12
`define OP_S1 11:9
`define OP_COND_VAL 11
`define OP_COND_FLAG 10:9
`define OP_SP_KIND 8:7
`define OP_A_FUNC 8:5
`define OP_A_SRC2 4:3
`define OP_A_DEST 2:0
`define OP_I_DEST 7:5
`define OP_SI_DEST 6:4
`define OP_SI_SHIFT 8:7

// ALU function codes
`define ALU_ADD 4'd0
`define ALU_SUB 4'd2

// ALU input A sources, codes 0 to 3 are registers
`define ALU1_FROM_PC 4'd4
`define ALU1_FROM_SP 4'd5
`define ALU1_FROM_MEM 4'd6
`define ALU1_FROM_HIMEM 4'd7

// ALU input B sources, codes 0 to 3 are registers
`define ALU2_FROM_1 4'd4
`define ALU2_FROM_0 4'd5
`define ALU2_FROM_OP 4'd6
`define ALU2_FROM_ADDR 4'd7
`define ALU2_FROM_FP 4'd8

// Memory address sources
`define READ_FROM_PC 3'd0
`define READ_FROM_A 3'd1
`define READ_FROM_SP 3'd2
`define READ_FROM_ALU 3'd3

// Memory write data sources
`define WRITE_FROM_ALU 4'd0
`define WRITE_FROM_RES 4'd1

// Destination codes, memory codes share the read-mode encoding
`define DEST_0 3'd0
`define DEST_A 3'd1
`define DEST_B 3'd2
`define DEST_C 3'd3
`define DEST_ADR 3'd6
`define DEST_ABS 3'd5
`define DEST_STACK 3'd7

// Source read modes (s1 with bit 2 set)
`define SRC_IMMED 3'd4
`define SRC_ABS 3'd5
`define SRC_ADDR 3'd6
`define SRC_STACK 3'd7

`endif
